//--- rename_pkg.sv
// rename package with register widths, reset constants and the opcode encoding
package rename_pkg;

  ////////////////////////////////////////////////////////////
  // register file sizes
  ////////////////////////////////////////////////////////////

  // architectural registers seen by software
  localparam int NUM_LREGS = 16;
  localparam int LREG_W = 4;

  // physical registers behind the map
  localparam int NUM_PREGS = 64;
  localparam int PREG_W = 6;

  // registers not mapped after reset sit in the free list
  localparam int NUM_FREE = NUM_PREGS - NUM_LREGS;
  localparam int FREE_CNT_W = 6;
  localparam int FREE_PTR_W = 6;

  // last slot of the circular free buffer, pointers wrap after it
  localparam logic [FREE_PTR_W-1:0] FREE_LAST = FREE_PTR_W'(NUM_FREE - 1);

  ////////////////////////////////////////////////////////////
  // reset constants
  ////////////////////////////////////////////////////////////

  // logical n maps to physical n, value already present
  localparam logic MAP_RST_RDY = 1'b1;

  // free list holds NUM_LREGS up to NUM_PREGS-1, lowest at the head
  localparam logic [PREG_W-1:0] FREE_RST_BASE = PREG_W'(NUM_LREGS);
  localparam logic [FREE_CNT_W-1:0] FREE_RST_CNT = FREE_CNT_W'(NUM_FREE);

  // a disabled source reads as physical 0 and is always ready
  localparam logic [PREG_W-1:0] DIS_PSRC = '0;
  localparam logic DIS_RDY = 1'b1;

  // opcodes, only alu and load produce a register result
  typedef enum logic [2:0] {
    OP_NOP    = 3'd0,
    OP_ALU    = 3'd1,
    OP_LOAD   = 3'd2,
    OP_STORE  = 3'd3,
    OP_BRANCH = 3'd4
  } opcode_e;

endpackage

//--- rename_map_table.sv
// logical to physical register map with ready bits, two lookups and one rename write
module rename_map_table (
  input  logic                         clk,
  input  logic                         rst_n,
  // lookup indices from the incoming instruction
  input  logic [rename_pkg::LREG_W-1:0] rd1_idx_i,
  input  logic [rename_pkg::LREG_W-1:0] rd2_idx_i,
  input  logic [rename_pkg::LREG_W-1:0] dst_idx_i,
  // rename write of the destination entry
  input  logic                         wr_en_i,
  input  logic [rename_pkg::PREG_W-1:0] wr_preg_i,
  // writeback broadcast
  input  logic                         wb_valid_i,
  input  logic [rename_pkg::PREG_W-1:0] wb_preg_i,
  // lookup results
  output logic [rename_pkg::PREG_W-1:0] rd1_preg_o,
  output logic                         rd1_rdy_o,
  output logic [rename_pkg::PREG_W-1:0] rd2_preg_o,
  output logic                         rd2_rdy_o,
  output logic [rename_pkg::PREG_W-1:0] dst_old_preg_o
);

  // one physical index and one ready bit per logical register
  logic [rename_pkg::PREG_W-1:0] preg_q [rename_pkg::NUM_LREGS];
  logic [rename_pkg::NUM_LREGS-1:0] rdy_q;

  // current mapping of each read port before forwarding
  logic [rename_pkg::PREG_W-1:0] rd1_map;
  logic [rename_pkg::PREG_W-1:0] rd2_map;

  ////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////

  // reads see the table as it stood before this edge,
  // so an instruction naming its own dst gets the old mapping
  assign rd1_map = preg_q[rd1_idx_i];
  assign rd2_map = preg_q[rd2_idx_i];

  assign rd1_preg_o = rd1_map;
  assign rd2_preg_o = rd2_map;

  // same-cycle writeback is forwarded into the ready bit
  assign rd1_rdy_o = rdy_q[rd1_idx_i] | (wb_valid_i && (wb_preg_i == rd1_map));
  assign rd2_rdy_o = rdy_q[rd2_idx_i] | (wb_valid_i && (wb_preg_i == rd2_map));

  // mapping being replaced, commit frees it later
  assign dst_old_preg_o = preg_q[dst_idx_i];

  ////////////////////////////////////////////////////////////
  // update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // identity map, everything ready
      for (int i = 0; i < rename_pkg::NUM_LREGS; i++)
      begin
        preg_q[i] <= i[rename_pkg::PREG_W-1:0];
        rdy_q[i]  <= rename_pkg::MAP_RST_RDY;
      end
    end
    else
    begin
      // writeback compares every entry in parallel
      for (int i = 0; i < rename_pkg::NUM_LREGS; i++)
      begin
        if (wb_valid_i && (preg_q[i] == wb_preg_i))
        begin
          rdy_q[i] <= 1'b1;
        end
      end
      // rename write comes last so it wins over a writeback
      // hitting the mapping it replaces
      if (wr_en_i)
      begin
        preg_q[dst_idx_i] <= wr_preg_i;
        rdy_q[dst_idx_i]  <= 1'b0;
      end
    end
  end

endmodule

//--- rename_free_list.sv
// circular FIFO of free physical register indices, popped on allocation, pushed on release
module rename_free_list (
  input  logic                         clk,
  input  logic                         rst_n,
  // allocation takes the head entry
  input  logic                         pop_i,
  // released register from commit
  input  logic                         push_i,
  input  logic [rename_pkg::PREG_W-1:0] push_preg_i,
  // next register to hand out
  output logic [rename_pkg::PREG_W-1:0] head_preg_o,
  output logic                         empty_o
);

  // storage and bookkeeping
  logic [rename_pkg::PREG_W-1:0] buf_q [rename_pkg::NUM_FREE];
  logic [rename_pkg::FREE_PTR_W-1:0] rd_ptr_q;
  logic [rename_pkg::FREE_PTR_W-1:0] wr_ptr_q;
  logic [rename_pkg::FREE_CNT_W-1:0] cnt_q;

  // pop only when something is there
  logic pop_ok;

  // pointer step with wrap at the last slot
  function automatic logic [rename_pkg::FREE_PTR_W-1:0] ptr_inc(
    input logic [rename_pkg::FREE_PTR_W-1:0] ptr
  );
    if (ptr == rename_pkg::FREE_LAST)
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////

  assign empty_o     = (cnt_q == '0);
  assign head_preg_o = buf_q[rd_ptr_q];
  assign pop_ok      = pop_i && !empty_o;

  ////////////////////////////////////////////////////////////
  // pointers, count and storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // full after reset, write pointer has wrapped back to 0
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= rename_pkg::FREE_RST_CNT;
      // unmapped registers in ascending order
      for (int i = 0; i < rename_pkg::NUM_FREE; i++)
      begin
        buf_q[i] <= rename_pkg::FREE_RST_BASE + i[rename_pkg::PREG_W-1:0];
      end
    end
    else
    begin
      if (pop_ok)
      begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // released index becomes the head only once older entries drain
      if (push_i)
      begin
        buf_q[wr_ptr_q] <= push_preg_i;
        wr_ptr_q        <= ptr_inc(wr_ptr_q);
      end
      // push with pop keeps the count
      case ({push_i, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

//--- rename_stage.sv
// rename stage control: accept logic, lookup and allocation merge, renamed output register
module rename_stage (
  input  logic                         clk,
  input  logic                         rst_n,
  // incoming instruction
  input  logic                         in_valid_i,
  input  rename_pkg::opcode_e          in_op_i,
  input  logic                         in_src1_en_i,
  input  logic [rename_pkg::LREG_W-1:0] in_src1_i,
  input  logic                         in_src2_en_i,
  input  logic [rename_pkg::LREG_W-1:0] in_src2_i,
  input  logic [rename_pkg::LREG_W-1:0] in_dst_i,
  output logic                         in_ready_o,
  // renamed instruction
  output logic                         out_valid_o,
  output rename_pkg::opcode_e          out_op_o,
  output logic [rename_pkg::PREG_W-1:0] out_psrc1_o,
  output logic                         out_psrc1_rdy_o,
  output logic [rename_pkg::PREG_W-1:0] out_psrc2_o,
  output logic                         out_psrc2_rdy_o,
  output logic [rename_pkg::PREG_W-1:0] out_pdst_o,
  output logic                         out_dst_wr_o,
  output logic [rename_pkg::PREG_W-1:0] out_old_pdst_o,
  output logic                         out_inst_rdy_o,
  input  logic                         out_ready_i,
  // map table lookup
  output logic [rename_pkg::LREG_W-1:0] rd1_idx_o,
  output logic [rename_pkg::LREG_W-1:0] rd2_idx_o,
  output logic [rename_pkg::LREG_W-1:0] dst_idx_o,
  input  logic [rename_pkg::PREG_W-1:0] rd1_preg_i,
  input  logic                         rd1_rdy_i,
  input  logic [rename_pkg::PREG_W-1:0] rd2_preg_i,
  input  logic                         rd2_rdy_i,
  input  logic [rename_pkg::PREG_W-1:0] dst_old_preg_i,
  // free list
  input  logic [rename_pkg::PREG_W-1:0] head_preg_i,
  input  logic                         fl_empty_i,
  output logic                         alloc_o
);

  // decode and handshake
  logic wr_dst;
  logic slot_free;
  logic accept;

  // merged source operands
  logic [rename_pkg::PREG_W-1:0] psrc1;
  logic [rename_pkg::PREG_W-1:0] psrc2;
  logic psrc1_rdy;
  logic psrc2_rdy;

  // output slot
  logic out_valid_q;
  rename_pkg::opcode_e op_q;
  logic [rename_pkg::PREG_W-1:0] psrc1_q;
  logic [rename_pkg::PREG_W-1:0] psrc2_q;
  logic [rename_pkg::PREG_W-1:0] pdst_q;
  logic [rename_pkg::PREG_W-1:0] old_pdst_q;
  logic psrc1_rdy_q;
  logic psrc2_rdy_q;
  logic dst_wr_q;

  ////////////////////////////////////////////////////////////
  // decode and accept
  ////////////////////////////////////////////////////////////

  // map table is indexed straight from the instruction fields
  assign rd1_idx_o = in_src1_i;
  assign rd2_idx_o = in_src2_i;
  assign dst_idx_o = in_dst_i;

  // only alu and load results need a new physical register
  assign wr_dst = (in_op_i == rename_pkg::OP_ALU) || (in_op_i == rename_pkg::OP_LOAD);

  // single slot, free when empty or leaving this edge
  assign slot_free = !out_valid_q || out_ready_i;

  // a writer also needs a register from the free list
  assign in_ready_o = slot_free && (!wr_dst || !fl_empty_i);
  assign accept     = in_valid_i && in_ready_o;

  // pops the free list and writes the map in the same edge
  assign alloc_o = accept && wr_dst;

  ////////////////////////////////////////////////////////////
  // operand merge
  ////////////////////////////////////////////////////////////

  // disabled source never blocks issue
  assign psrc1     = in_src1_en_i ? rd1_preg_i : rename_pkg::DIS_PSRC;
  assign psrc1_rdy = in_src1_en_i ? rd1_rdy_i  : rename_pkg::DIS_RDY;
  assign psrc2     = in_src2_en_i ? rd2_preg_i : rename_pkg::DIS_PSRC;
  assign psrc2_rdy = in_src2_en_i ? rd2_rdy_i  : rename_pkg::DIS_RDY;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid_q <= 1'b0;
    end
    else if (accept)
    begin
      out_valid_q <= 1'b1;
    end
    else if (out_ready_i)
    begin
      out_valid_q <= 1'b0;
    end
  end

  // payload only moves on accept, so it holds under stall
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q        <= in_op_i;
      psrc1_q     <= psrc1;
      psrc1_rdy_q <= psrc1_rdy;
      psrc2_q     <= psrc2;
      psrc2_rdy_q <= psrc2_rdy;
      dst_wr_q    <= wr_dst;
      // no destination reports zeros
      pdst_q      <= wr_dst ? head_preg_i : '0;
      old_pdst_q  <= wr_dst ? dst_old_preg_i : '0;
    end
  end

  assign out_valid_o     = out_valid_q;
  assign out_op_o        = op_q;
  assign out_psrc1_o     = psrc1_q;
  assign out_psrc1_rdy_o = psrc1_rdy_q;
  assign out_psrc2_o     = psrc2_q;
  assign out_psrc2_rdy_o = psrc2_rdy_q;
  assign out_pdst_o      = pdst_q;
  assign out_dst_wr_o    = dst_wr_q;
  assign out_old_pdst_o  = old_pdst_q;
  // ready bits are frozen at rename, scheduler tracks them from here
  assign out_inst_rdy_o  = psrc1_rdy_q && psrc2_rdy_q;

endmodule

//--- rename_unit.sv
// register rename unit top, joins map table, free list and rename stage
module rename_unit (
  input  logic                         clk,
  input  logic                         rst_n,
  // instruction in
  input  logic                         in_valid_i,
  input  rename_pkg::opcode_e          in_op_i,
  input  logic                         in_src1_en_i,
  input  logic [rename_pkg::LREG_W-1:0] in_src1_i,
  input  logic                         in_src2_en_i,
  input  logic [rename_pkg::LREG_W-1:0] in_src2_i,
  input  logic [rename_pkg::LREG_W-1:0] in_dst_i,
  output logic                         in_ready_o,
  // renamed instruction out
  output logic                         out_valid_o,
  output rename_pkg::opcode_e          out_op_o,
  output logic [rename_pkg::PREG_W-1:0] out_psrc1_o,
  output logic                         out_psrc1_rdy_o,
  output logic [rename_pkg::PREG_W-1:0] out_psrc2_o,
  output logic                         out_psrc2_rdy_o,
  output logic [rename_pkg::PREG_W-1:0] out_pdst_o,
  output logic                         out_dst_wr_o,
  output logic [rename_pkg::PREG_W-1:0] out_old_pdst_o,
  output logic                         out_inst_rdy_o,
  input  logic                         out_ready_i,
  // writeback
  input  logic                         wb_valid_i,
  input  logic [rename_pkg::PREG_W-1:0] wb_preg_i,
  // release from commit
  input  logic                         rel_valid_i,
  input  logic [rename_pkg::PREG_W-1:0] rel_preg_i
);

  ////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////

  // lookup indices
  logic [rename_pkg::LREG_W-1:0] rd1_idx;
  logic [rename_pkg::LREG_W-1:0] rd2_idx;
  logic [rename_pkg::LREG_W-1:0] dst_idx;

  // lookup results
  logic [rename_pkg::PREG_W-1:0] rd1_preg;
  logic rd1_rdy;
  logic [rename_pkg::PREG_W-1:0] rd2_preg;
  logic rd2_rdy;
  logic [rename_pkg::PREG_W-1:0] dst_old_preg;

  // allocation
  logic [rename_pkg::PREG_W-1:0] head_preg;
  logic empty;
  logic alloc;

  // head register goes both to the map write and to the stage
  rename_map_table i_map_table (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd1_idx_i      (rd1_idx),
    .rd2_idx_i      (rd2_idx),
    .dst_idx_i      (dst_idx),
    .wr_en_i        (alloc),
    .wr_preg_i      (head_preg),
    .wb_valid_i     (wb_valid_i),
    .wb_preg_i      (wb_preg_i),
    .rd1_preg_o     (rd1_preg),
    .rd1_rdy_o      (rd1_rdy),
    .rd2_preg_o     (rd2_preg),
    .rd2_rdy_o      (rd2_rdy),
    .dst_old_preg_o (dst_old_preg)
  );

  rename_free_list i_free_list (
    .clk         (clk),
    .rst_n       (rst_n),
    .pop_i       (alloc),
    .push_i      (rel_valid_i),
    .push_preg_i (rel_preg_i),
    .head_preg_o (head_preg),
    .empty_o     (empty)
  );

  rename_stage i_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid_i      (in_valid_i),
    .in_op_i         (in_op_i),
    .in_src1_en_i    (in_src1_en_i),
    .in_src1_i       (in_src1_i),
    .in_src2_en_i    (in_src2_en_i),
    .in_src2_i       (in_src2_i),
    .in_dst_i        (in_dst_i),
    .in_ready_o      (in_ready_o),
    .out_valid_o     (out_valid_o),
    .out_op_o        (out_op_o),
    .out_psrc1_o     (out_psrc1_o),
    .out_psrc1_rdy_o (out_psrc1_rdy_o),
    .out_psrc2_o     (out_psrc2_o),
    .out_psrc2_rdy_o (out_psrc2_rdy_o),
    .out_pdst_o      (out_pdst_o),
    .out_dst_wr_o    (out_dst_wr_o),
    .out_old_pdst_o  (out_old_pdst_o),
    .out_inst_rdy_o  (out_inst_rdy_o),
    .out_ready_i     (out_ready_i),
    .rd1_idx_o       (rd1_idx),
    .rd2_idx_o       (rd2_idx),
    .dst_idx_o       (dst_idx),
    .rd1_preg_i      (rd1_preg),
    .rd1_rdy_i       (rd1_rdy),
    .rd2_preg_i      (rd2_preg),
    .rd2_rdy_i       (rd2_rdy),
    .dst_old_preg_i  (dst_old_preg),
    .head_preg_i     (head_preg),
    .fl_empty_i      (empty),
    .alloc_o         (alloc)
  );

endmodule

//--- rename_unit_checker.sv
// handshake and allocation assertions, bound into the rename stage
module rename_unit_checker (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          in_valid_i,
  input rename_pkg::opcode_e           in_op_i,
  input logic                          out_valid_i,
  input logic                          out_ready_i,
  input rename_pkg::opcode_e           out_op_i,
  input logic [rename_pkg::PREG_W-1:0] out_psrc1_i,
  input logic                          out_psrc1_rdy_i,
  input logic [rename_pkg::PREG_W-1:0] out_psrc2_i,
  input logic                          out_psrc2_rdy_i,
  input logic [rename_pkg::PREG_W-1:0] out_pdst_i,
  input logic [rename_pkg::PREG_W-1:0] out_old_pdst_i,
  input logic                          out_dst_wr_i,
  input logic                          out_inst_rdy_i,
  input logic [rename_pkg::PREG_W-1:0] head_preg_i,
  input logic                          fl_empty_i,
  input logic                          alloc_i
);

  // alu and load are the only producers
  logic wr_op;

  assign wr_op = (in_op_i == rename_pkg::OP_ALU) || (in_op_i == rename_pkg::OP_LOAD);

  ////////////////////////////////////////////////////////////
  // output slot
  ////////////////////////////////////////////////////////////

  // stalled instruction keeps every field
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_op_i)
      && $stable(out_psrc1_i) && $stable(out_psrc1_rdy_i)
      && $stable(out_psrc2_i) && $stable(out_psrc2_rdy_i) && $stable(out_pdst_i)
      && $stable(out_old_pdst_i) && $stable(out_dst_wr_i) && $stable(out_inst_rdy_i))
    else $error("renamed instruction changed while the output was stalled");

  ////////////////////////////////////////////////////////////
  // allocation
  ////////////////////////////////////////////////////////////

  // a writer meeting a dry pool with the slot free leaves the slot empty
  a_no_empty_accept: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid_i && wr_op && fl_empty_i && (!out_valid_i || out_ready_i) |=> !out_valid_i)
    else $error("writing instruction accepted with an empty free list");

  // every pop shows up as a renamed writer carrying the popped register
  a_alloc_accept: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_i |=> out_valid_i && out_dst_wr_i && (out_pdst_i == $past(head_preg_i)))
    else $error("allocation without an accepted writing instruction");

endmodule

bind rename_stage rename_unit_checker i_checker (
  .clk             (clk),
  .rst_n           (rst_n),
  .in_valid_i      (in_valid_i),
  .in_op_i         (in_op_i),
  .out_valid_i     (out_valid_o),
  .out_ready_i     (out_ready_i),
  .out_op_i        (out_op_o),
  .out_psrc1_i     (out_psrc1_o),
  .out_psrc1_rdy_i (out_psrc1_rdy_o),
  .out_psrc2_i     (out_psrc2_o),
  .out_psrc2_rdy_i (out_psrc2_rdy_o),
  .out_pdst_i      (out_pdst_o),
  .out_old_pdst_i  (out_old_pdst_o),
  .out_dst_wr_i    (out_dst_wr_o),
  .out_inst_rdy_i  (out_inst_rdy_o),
  .head_preg_i     (head_preg_i),
  .fl_empty_i      (fl_empty_i),
  .alloc_i         (alloc_o)
);

//--- rename_unit_tb.sv
// testbench for the rename unit, directed table, exhaustion and LFSR random phase
module rename_unit_tb;

  localparam int N_ROWS = 11;
  localparam int N_RAND = 300;
  localparam int WAIT_MAX = 20;
  localparam int WATCH_CYCLES = (N_ROWS + N_RAND) * 40;

  // one instruction with its expected renamed form
  typedef struct {
    string name;
    rename_pkg::opcode_e op;
    int s1en, s1, s2en, s2, dst;
    int wb, wbp, rel, relp, ordy;
    int e_p1, e_r1, e_p2, e_r2, e_pd, e_old, e_ir;
  } row_t;

  logic clk;
  logic rst_n;
  logic in_valid_i;
  rename_pkg::opcode_e in_op_i;
  logic in_src1_en_i;
  logic [rename_pkg::LREG_W-1:0] in_src1_i;
  logic in_src2_en_i;
  logic [rename_pkg::LREG_W-1:0] in_src2_i;
  logic [rename_pkg::LREG_W-1:0] in_dst_i;
  logic in_ready_o;
  logic out_valid_o;
  rename_pkg::opcode_e out_op_o;
  logic [rename_pkg::PREG_W-1:0] out_psrc1_o;
  logic out_psrc1_rdy_o;
  logic [rename_pkg::PREG_W-1:0] out_psrc2_o;
  logic out_psrc2_rdy_o;
  logic [rename_pkg::PREG_W-1:0] out_pdst_o;
  logic out_dst_wr_o;
  logic [rename_pkg::PREG_W-1:0] out_old_pdst_o;
  logic out_inst_rdy_o;
  logic out_ready_i;
  logic wb_valid_i;
  logic [rename_pkg::PREG_W-1:0] wb_preg_i;
  logic rel_valid_i;
  logic [rename_pkg::PREG_W-1:0] rel_preg_i;

  row_t rows [$];
  logic [31:0] lfsr_state = 32'h7da13f5a;
  int n_errors = 0;
  int n_tests = 0;
  int n_failed = 0;
  int mark;

  rename_unit i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit scales with the number of tests
  initial
  begin
    #(WATCH_CYCLES * 20);
    $display("watchdog expired after %0d cycles, simulation did not finish", WATCH_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | int'(next_bit());
    end
    return v;
  endfunction

  // alu and load write a destination
  function automatic int writes_dst(input rename_pkg::opcode_e op);
    return (op == rename_pkg::OP_ALU || op == rename_pkg::OP_LOAD) ? 1 : 0;
  endfunction

  task automatic check(input string test, input string what, input logic [31:0] exp,
                       input logic [31:0] act);
    if (exp !== act)
    begin
      $display("error %s %s: expected %0d, actual %0d", test, what, exp, act);
      n_errors++;
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    n_tests++;
    if (n_errors == start_errors)
    begin
      $display("test %s: ok", name);
    end
    else
    begin
      n_failed++;
      $display("test %s: %0d mismatches", name, n_errors - start_errors);
    end
  endtask

  // all inputs idle, reset held for two edges
  task automatic apply_reset();
    rst_n = 1'b0;
    in_valid_i = 1'b0;
    in_op_i = rename_pkg::OP_NOP;
    in_src1_en_i = 1'b0;
    in_src1_i = '0;
    in_src2_en_i = 1'b0;
    in_src2_i = '0;
    in_dst_i = '0;
    out_ready_i = 1'b1;
    wb_valid_i = 1'b0;
    wb_preg_i = '0;
    rel_valid_i = 1'b0;
    rel_preg_i = '0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  // one push into the free list
  task automatic release_preg(input int p);
    rel_valid_i = 1'b1;
    rel_preg_i = 6'(p);
    @(posedge clk);
    #2;
    rel_valid_i = 1'b0;
  endtask

  task automatic check_out(input row_t r);
    check(r.name, "out_valid", 1, 32'(out_valid_o));
    check(r.name, "op", 32'(r.op), 32'(out_op_o));
    check(r.name, "psrc1", r.e_p1, 32'(out_psrc1_o));
    check(r.name, "psrc1_rdy", r.e_r1, 32'(out_psrc1_rdy_o));
    check(r.name, "psrc2", r.e_p2, 32'(out_psrc2_o));
    check(r.name, "psrc2_rdy", r.e_r2, 32'(out_psrc2_rdy_o));
    check(r.name, "pdst", r.e_pd, 32'(out_pdst_o));
    check(r.name, "dst_wr", writes_dst(r.op), 32'(out_dst_wr_o));
    check(r.name, "old_pdst", r.e_old, 32'(out_old_pdst_o));
    check(r.name, "inst_rdy", r.e_ir, 32'(out_inst_rdy_o));
  endtask

  // drive one instruction, wait for the handshake, check the output slot
  task automatic issue(input row_t r);
    int waited;
    waited = 0;
    if (r.rel != 0)
    begin
      release_preg(r.relp);
    end
    in_valid_i = 1'b1;
    in_op_i = r.op;
    in_src1_en_i = (r.s1en != 0);
    in_src1_i = 4'(r.s1);
    in_src2_en_i = (r.s2en != 0);
    in_src2_i = 4'(r.s2);
    in_dst_i = 4'(r.dst);
    wb_valid_i = (r.wb != 0);
    wb_preg_i = 6'(r.wbp);
    out_ready_i = 1'b1;
    #1;
    while (!in_ready_o && waited < WAIT_MAX)
    begin
      @(posedge clk);
      #3;
      waited++;
    end
    if (!in_ready_o)
    begin
      $display("%s: in_ready_o stayed low, instruction never accepted", r.name);
      n_errors++;
      in_valid_i = 1'b0;
      wb_valid_i = 1'b0;
      return;
    end
    @(posedge clk);
    #2;
    in_valid_i = 1'b0;
    wb_valid_i = 1'b0;
    out_ready_i = (r.ordy != 0);
    check_out(r);
    // held slot blocks the input
    if (r.ordy == 0)
    begin
      repeat (3)
      begin
        @(posedge clk);
        #2;
        check_out(r);
        check(r.name, "in_ready_stall", 0, 32'(in_ready_o));
      end
      out_ready_i = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed table, state carries over from row to row
  ////////////////////////////////////////////////////////////

  // name, op, s1en s1 s2en s2 dst, wb wbp rel relp ordy,
  // then psrc1 rdy1 psrc2 rdy2 pdst old_pdst inst_rdy
  task automatic load_table();
    rows.push_back(row_t'{"reset_map", rename_pkg::OP_STORE, 1, 0, 1, 15, 2, 0, 0, 0, 0, 1,
                          0, 1, 15, 1, 0, 0, 1});
    rows.push_back(row_t'{"alloc_16", rename_pkg::OP_ALU, 1, 1, 1, 2, 5, 0, 0, 0, 0, 1,
                          1, 1, 2, 1, 16, 5, 1});
    rows.push_back(row_t'{"reader_new", rename_pkg::OP_LOAD, 1, 5, 0, 0, 6, 0, 0, 0, 0, 1,
                          16, 0, 0, 1, 17, 6, 0});
    rows.push_back(row_t'{"self_read", rename_pkg::OP_ALU, 1, 6, 1, 6, 6, 0, 0, 0, 0, 1,
                          17, 0, 17, 0, 18, 17, 0});
    rows.push_back(row_t'{"wb_same_cycle", rename_pkg::OP_ALU, 1, 6, 1, 5, 7, 1, 18, 0, 0, 1,
                          18, 1, 16, 0, 19, 7, 0});
    rows.push_back(row_t'{"wb_later", rename_pkg::OP_STORE, 1, 6, 1, 7, 3, 0, 0, 0, 0, 1,
                          18, 1, 19, 0, 0, 0, 0});
    rows.push_back(row_t'{"branch_no_wr", rename_pkg::OP_BRANCH, 1, 5, 0, 0, 5, 0, 0, 0, 0, 1,
                          16, 0, 0, 1, 0, 0, 0});
    rows.push_back(row_t'{"nop_disabled", rename_pkg::OP_NOP, 0, 4, 0, 8, 9, 0, 0, 0, 0, 1,
                          0, 1, 0, 1, 0, 0, 1});
    rows.push_back(row_t'{"map_kept", rename_pkg::OP_ALU, 1, 9, 1, 5, 5, 1, 16, 0, 0, 1,
                          9, 1, 16, 1, 20, 16, 1});
    rows.push_back(row_t'{"stall_hold", rename_pkg::OP_ALU, 1, 7, 1, 3, 8, 0, 0, 0, 0, 0,
                          19, 0, 3, 1, 21, 8, 0});
    rows.push_back(row_t'{"after_stall", rename_pkg::OP_LOAD, 1, 8, 0, 0, 1, 0, 0, 1, 5, 1,
                          21, 0, 0, 1, 22, 1, 0});
  endtask

  // drain all 48 free registers, then refill with one release
  task automatic exhaust_free_list();
    row_t r;
    // dst i%16 last got register i, so old pdst is always i
    for (int i = 0; i < rename_pkg::NUM_FREE; i++)
    begin
      r = '{"exhaust", rename_pkg::OP_ALU, 0, 0, 0, 0, i % 16, 0, 0, 0, 0, 1,
            0, 1, 0, 1, 16 + i, i, 1};
      issue(r);
    end
    in_valid_i = 1'b1;
    in_op_i = rename_pkg::OP_ALU;
    in_dst_i = 4'd3;
    #1;
    check("exhaust", "in_ready_alu_empty", 0, 32'(in_ready_o));
    @(posedge clk);
    #3;
    check("exhaust", "in_ready_alu_empty", 0, 32'(in_ready_o));
    in_op_i = rename_pkg::OP_STORE;
    #1;
    check("exhaust", "in_ready_store_empty", 1, 32'(in_ready_o));
    // release seen only after the edge
    in_op_i = rename_pkg::OP_ALU;
    rel_valid_i = 1'b1;
    rel_preg_i = 6'd5;
    #1;
    check("exhaust", "in_ready_during_release", 0, 32'(in_ready_o));
    @(posedge clk);
    #2;
    rel_valid_i = 1'b0;
    #1;
    check("exhaust", "in_ready_after_release", 1, 32'(in_ready_o));
    in_valid_i = 1'b0;
    r = '{"exhaust_reuse", rename_pkg::OP_ALU, 0, 0, 0, 0, 3, 0, 0, 0, 0, 1,
          0, 1, 0, 1, 5, 51, 1};
    issue(r);
  endtask

  ////////////////////////////////////////////////////////////
  // random phase against a reference model
  ////////////////////////////////////////////////////////////

  task automatic random_phase();
    int map_m [16];
    int rdy_m [64];
    int free_m [$];
    int pend_preg [$];
    int pend_due [$];
    int wr;
    row_t r;
    for (int i = 0; i < 16; i++)
    begin
      map_m[4'(i)] = i;
    end
    // ready is tracked per physical register here
    for (int i = 0; i < 64; i++)
    begin
      rdy_m[6'(i)] = (i < 16) ? 1 : 0;
      if (i >= 16)
      begin
        free_m.push_back(i);
      end
    end
    for (int k = 0; k < N_RAND; k++)
    begin
      // hand back old registers whose delay ran out
      while (pend_due.size() > 0 && pend_due[0] <= k)
      begin
        release_preg(pend_preg[0]);
        free_m.push_back(pend_preg.pop_front());
        void'(pend_due.pop_front());
      end
      r.name = $sformatf("random_%0d", k);
      r.op = rename_pkg::opcode_e'(3'(rand_bits(3) % 5));
      r.s1en = rand_bits(1);
      r.s1 = rand_bits(4);
      r.s2en = rand_bits(1);
      r.s2 = rand_bits(4);
      r.dst = rand_bits(4);
      r.wb = rand_bits(1);
      r.wbp = map_m[4'(rand_bits(4))];
      r.rel = 0;
      r.relp = 0;
      r.ordy = (rand_bits(3) != 0) ? 1 : 0;
      wr = writes_dst(r.op);
      r.e_p1 = (r.s1en != 0) ? map_m[4'(r.s1)] : 0;
      r.e_r1 = (r.s1en == 0 || rdy_m[6'(r.e_p1)] != 0 || (r.wb != 0 && r.wbp == r.e_p1)) ? 1 : 0;
      r.e_p2 = (r.s2en != 0) ? map_m[4'(r.s2)] : 0;
      r.e_r2 = (r.s2en == 0 || rdy_m[6'(r.e_p2)] != 0 || (r.wb != 0 && r.wbp == r.e_p2)) ? 1 : 0;
      r.e_pd = (wr != 0) ? free_m[0] : 0;
      r.e_old = (wr != 0) ? map_m[4'(r.dst)] : 0;
      r.e_ir = (r.e_r1 != 0 && r.e_r2 != 0) ? 1 : 0;
      issue(r);
      if (r.wb != 0)
      begin
        rdy_m[6'(r.wbp)] = 1;
      end
      // new mapping starts not ready, old one goes back later
      if (wr != 0)
      begin
        pend_preg.push_back(map_m[4'(r.dst)]);
        pend_due.push_back(k + 1 + rand_bits(3));
        map_m[4'(r.dst)] = free_m.pop_front();
        rdy_m[6'(map_m[4'(r.dst)])] = 0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    apply_reset();
    load_table();
    for (int i = 0; i < rows.size(); i++)
    begin
      mark = n_errors;
      issue(rows[i]);
      end_test(rows[i].name, mark);
    end
    apply_reset();
    mark = n_errors;
    exhaust_free_list();
    end_test("exhaust", mark);
    apply_reset();
    mark = n_errors;
    random_phase();
    end_test("random", mark);
    $display("%0d tests, %0d failed, %0d mismatches", n_tests, n_failed, n_errors);
    if (n_errors == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- rename_unit.f
rename_pkg.sv
rename_map_table.sv
rename_free_list.sv
rename_stage.sv
rename_unit.sv
rename_unit_checker.sv
rename_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the rename unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module rename_unit_tb \
  -f rename_unit.f

# a failing run still prints its output before the verdict
out=$(./obj_dir/Vrename_unit_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qF 'All tests passed!'; then
  exit 0
else
  exit 1
fi
